// ==== Bender.yml ====
package:
  name: mult_fu

sources:
  - source/mult_pkg.sv
  - source/mult_stage.sv
  - source/mult_pipe.sv
  - source/mult_issue_queue.sv
  - source/mult_complete_buffer.sv
  - source/mult_unit.sv
  - target: test
    files:
      - bench/mult_unit_tb.sv

// ==== bench/mult_unit_tb.sv ====
`default_nettype none

module mult_unit_tb;

    import mult_pkg::*;

    localparam int STAGES      = 4;
    localparam int TAG_WIDTH   = 6;
    localparam int QUEUE_DEPTH = 4;
    localparam int TIMEOUT     = 1000; // cycles allowed for any single wait

    logic                  clock;
    logic                  reset;
    logic                  issue_valid;
    mult_func_e            issue_func;
    logic [data_width-1:0] issue_rs1;
    logic [data_width-1:0] issue_rs2;
    logic [TAG_WIDTH-1:0]  issue_tag;
    logic                  complete_ready;
    logic                  issue_ready;
    logic                  complete_valid;
    logic [data_width-1:0] complete_result;
    logic [TAG_WIDTH-1:0]  complete_tag;

    // scoreboard, in issue order
    logic [TAG_WIDTH-1:0]  exp_tag    [$];
    logic [data_width-1:0] exp_result [$];

    logic                  held;        // completion was blocked on the last edge
    logic [data_width-1:0] held_result;
    logic [TAG_WIDTH-1:0]  held_tag;
    logic [TAG_WIDTH-1:0]  next_tag;
    int                    ready_mode;  // 0 high, 1 random, 2 low

    mult_unit #(
        .STAGES      (STAGES),
        .TAG_WIDTH   (TAG_WIDTH),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_mult_unit (
        .clock           (clock),
        .reset           (reset),
        .issue_valid     (issue_valid),
        .issue_func      (issue_func),
        .issue_rs1       (issue_rs1),
        .issue_rs2       (issue_rs2),
        .issue_tag       (issue_tag),
        .complete_ready  (complete_ready),
        .issue_ready     (issue_ready),
        .complete_valid  (complete_valid),
        .complete_result (complete_result),
        .complete_tag    (complete_tag)
    );

    always #2 clock = ~clock;

    // RV32M result from plain 64-bit arithmetic
    function automatic logic [data_width-1:0] ref_mult(input mult_func_e func,
                                                       input logic [31:0] a,
                                                       input logic [31:0] b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [63:0] zb;
        logic [63:0]        ua;
        logic [63:0]        ub;
        logic [63:0]        prod;
        sa = $signed(a);
        sb = $signed(b);
        zb = {32'b0, b};
        ua = {32'b0, a};
        ub = {32'b0, b};
        case (func)
            MUL:     prod = sa * sb;
            MULH:    prod = sa * sb;
            MULHSU:  prod = sa * zb; // rs2 taken as unsigned
            default: prod = ua * ub;
        endcase
        return (func == MUL) ? prod[31:0] : prod[63:32];
    endfunction

    task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("ERR %0t: %s, got %0h expected %0h", $time, what, actual, expected);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t: %s did not happen within %0d cycles", $time, what, TIMEOUT);
        $display("Simulation failed");
        $fatal(1, "wait timed out");
    endtask

    // one clock, ending on the falling edge where inputs change
    task automatic next_cycle();
        @(negedge clock);
        case (ready_mode)
            0:       complete_ready = 1'b1;
            1:       complete_ready = $urandom_range(1); // random back-pressure
            default: complete_ready = 1'b0;
        endcase
    endtask

    task automatic drive_op(input mult_func_e func, input logic [31:0] rs1,
                            input logic [31:0] rs2);
        issue_valid = 1'b1;
        issue_func  = func;
        issue_rs1   = rs1;
        issue_rs2   = rs2;
        issue_tag   = next_tag;
        next_tag    = next_tag + 1'b1;
    endtask

    // returns on the falling edge after the handshake, valid still high
    task automatic issue_op(input mult_func_e func, input logic [31:0] rs1,
                            input logic [31:0] rs2);
        int waited;
        waited = 0;
        drive_op(func, rs1, rs2);
        while (!issue_ready) begin
            next_cycle();
            waited++;
            if (waited > TIMEOUT) report_timeout("issue handshake");
        end
        next_cycle();
    endtask

    task automatic issue_random();
        issue_op(mult_func_e'($urandom_range(3)), $urandom, $urandom);
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        issue_valid = 1'b0;
        while (exp_tag.size() != 0 || complete_valid) begin
            next_cycle();
            waited++;
            if (waited > TIMEOUT) report_timeout("completion of all pending operations");
        end
    endtask

    // every accepted issue goes into the scoreboard
    always @(posedge clock) begin
        if (!reset && issue_valid && issue_ready) begin
            exp_tag.push_back(issue_tag);
            exp_result.push_back(ref_mult(issue_func, issue_rs1, issue_rs2));
        end
    end

    // compare process on the completion side
    always @(posedge clock) begin
        if (reset) begin
            exp_tag.delete();
            exp_result.delete();
            held = 1'b0;
        end else begin
            if (held) begin
                check_equal(complete_valid, 1'b1, "complete_valid dropped before handshake");
                check_equal(complete_result, held_result, "complete_result changed while held");
                check_equal(complete_tag, held_tag, "complete_tag changed while held");
            end
            if (complete_valid && complete_ready) begin
                if (exp_tag.size() == 0) begin
                    $display("Completion with tag %0d arrived while no operation was pending",
                             complete_tag);
                    $display("Simulation failed");
                    $fatal(1, "unexpected completion");
                end
                check_equal(complete_tag, exp_tag.pop_front(), "completion tag");
                check_equal(complete_result, exp_result.pop_front(), "completion result");
            end
            held        = complete_valid && !complete_ready;
            held_result = complete_result;
            held_tag    = complete_tag;
        end
    end

    initial begin
        logic [31:0] corner [7];
        int          cycles;
        int          attempts;
        corner = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff,
                   32'hffff_fff9, 32'h0001_2345};
        void'($urandom(89));
        clock          = 1'b0;
        reset          = 1'b1;
        issue_valid    = 1'b0;
        issue_func     = MUL;
        issue_rs1      = '0;
        issue_rs2      = '0;
        issue_tag      = '0;
        complete_ready = 1'b1;
        next_tag       = '0;
        ready_mode     = 0;
        held           = 1'b0;
        repeat (4) @(negedge clock);
        reset = 1'b0;

        // corner operands through all four functions
        for (int f = 0; f < 4; f++) begin
            for (int i = 0; i < 7; i++) begin
                for (int j = 0; j < 7; j++) begin
                    issue_op(mult_func_e'(f), corner[i], corner[j]);
                end
            end
        end
        wait_drain();

        // latency with nothing else in flight
        issue_op(MULH, 32'hdead_beef, 32'h1234_5678);
        issue_valid = 1'b0;
        cycles = 0;
        while (!complete_valid) begin
            next_cycle();
            cycles++;
            if (cycles > TIMEOUT) report_timeout("complete_valid after a single issue");
        end
        check_equal(cycles, STAGES + 2, "unloaded latency in cycles");
        wait_drain();

        repeat (200) issue_random(); // back to back
        wait_drain();

        ready_mode = 1;
        repeat (300) issue_random();
        wait_drain();

        // completion blocked until the queue fills
        ready_mode = 2;
        attempts   = 0;
        while (issue_ready) begin
            drive_op(mult_func_e'($urandom_range(3)), $urandom, $urandom);
            next_cycle();
            attempts++;
            if (attempts > TIMEOUT) report_timeout("issue_ready falling under back-pressure");
        end
        issue_valid = 1'b0;
        repeat (20) begin
            next_cycle();
            check_equal(issue_ready, 1'b0, "issue_ready while completion is blocked");
        end
        ready_mode = 0;
        wait_drain();

        // reset with operations in flight
        ready_mode = 1;
        repeat (6) issue_random();
        reset       = 1'b1;
        issue_valid = 1'b0;
        repeat (4) next_cycle();
        reset = 1'b0;
        check_equal(complete_valid, 1'b0, "complete_valid after reset");
        check_equal(issue_ready, 1'b1, "issue_ready after reset");
        check_equal(exp_tag.size(), 0, "scoreboard entries after reset");
        ready_mode = 0;
        repeat (STAGES + 6) begin
            next_cycle();
            check_equal(complete_valid, 1'b0, "complete_valid while idle after reset");
        end
        repeat (20) issue_random();
        wait_drain();

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== mult_fu.f ====
source/mult_pkg.sv
source/mult_stage.sv
source/mult_pipe.sv
source/mult_issue_queue.sv
source/mult_complete_buffer.sv
source/mult_unit.sv
bench/mult_unit_tb.sv

// ==== source/mult_complete_buffer.sv ====
`default_nettype none

module mult_complete_buffer #(
    parameter int TAG_WIDTH = 6
) (
    input  wire logic                           clock,
    input  wire logic                           reset,
    input  wire logic                           done,
    input  wire logic [mult_pkg::data_width-1:0] result,
    input  wire logic [TAG_WIDTH-1:0]           done_tag,
    input  wire logic                           complete_ready,
    output logic                                stall,
    output logic                                complete_valid,
    output logic [mult_pkg::data_width-1:0]     complete_result,
    output logic [TAG_WIDTH-1:0]                complete_tag
);

    logic load;

    // takes a new value when empty or when the current one leaves this cycle
    assign load  = !complete_valid || complete_ready;

    // held result with no taker, so everything upstream waits
    assign stall = complete_valid && !complete_ready;

    always_ff @(posedge clock) begin
        if (reset) begin
            complete_valid <= 1'b0;
        end else if (load) begin
            complete_valid <= done;
        end
    end

    always_ff @(posedge clock) begin
        if (load && done) begin
            complete_result <= result;
            complete_tag    <= done_tag;
        end
    end

    // completion side handshake rule
    a_complete_stable: assert property (
        @(posedge clock) disable iff (reset)
        complete_valid && !complete_ready |=>
            complete_valid && $stable(complete_result) && $stable(complete_tag)
    ) else $error("mult_complete_buffer: completion changed before handshake");

endmodule

`default_nettype wire

// ==== source/mult_issue_queue.sv ====
`default_nettype none

module mult_issue_queue #(
    parameter int QUEUE_DEPTH = 4,
    parameter int TAG_WIDTH   = 6
) (
    input  wire logic                           clock,
    input  wire logic                           reset,
    input  wire logic                           issue_valid,
    input  wire mult_pkg::mult_func_e           issue_func,
    input  wire logic [mult_pkg::data_width-1:0] issue_rs1,
    input  wire logic [mult_pkg::data_width-1:0] issue_rs2,
    input  wire logic [TAG_WIDTH-1:0]           issue_tag,
    input  wire logic                           stall,
    output logic                                issue_ready,
    output logic                                op_valid,
    output mult_pkg::mult_func_e                op_func,
    output logic [mult_pkg::data_width-1:0]     op_rs1,
    output logic [mult_pkg::data_width-1:0]     op_rs2,
    output logic [TAG_WIDTH-1:0]                op_tag
);

    import mult_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH); // depth is a power of two, at least 2
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    mult_func_e            func_mem [QUEUE_DEPTH];
    logic [data_width-1:0] rs1_mem  [QUEUE_DEPTH];
    logic [data_width-1:0] rs2_mem  [QUEUE_DEPTH];
    logic [TAG_WIDTH-1:0]  tag_mem  [QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign issue_ready = (count != CNT_W'(QUEUE_DEPTH));
    assign op_valid    = (count != '0);
    assign push        = issue_valid && issue_ready;
    assign pop         = op_valid && !stall; // the pipe takes the head whenever it moves

    // head entry read straight out of the array
    assign op_func = func_mem[rd_ptr];
    assign op_rs1  = rs1_mem[rd_ptr];
    assign op_rs2  = rs2_mem[rd_ptr];
    assign op_tag  = tag_mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (push) begin
            func_mem[wr_ptr] <= issue_func;
            rs1_mem[wr_ptr]  <= issue_rs1;
            rs2_mem[wr_ptr]  <= issue_rs2;
            tag_mem[wr_ptr]  <= issue_tag;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1; // pointers wrap on their own
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // count never passes the depth and always matches the pointer distance
    a_no_write_full: assert property (
        @(posedge clock) disable iff (reset)
        (count <= CNT_W'(QUEUE_DEPTH)) && (PTR_W'(wr_ptr - rd_ptr) == PTR_W'(count))
    ) else $error("mult_issue_queue: write into a full queue");

endmodule

`default_nettype wire

// ==== source/mult_pipe.sv ====
`default_nettype none

module mult_pipe #(
    parameter int STAGES    = 4,
    parameter int TAG_WIDTH = 6
) (
    input  wire logic                           clock,
    input  wire logic                           reset,
    input  wire logic                           stall,
    input  wire logic                           op_valid,
    input  wire mult_pkg::mult_func_e           op_func,
    input  wire logic [mult_pkg::data_width-1:0] op_rs1,
    input  wire logic [mult_pkg::data_width-1:0] op_rs2,
    input  wire logic [TAG_WIDTH-1:0]           op_tag,
    output logic                                done,
    output logic [mult_pkg::data_width-1:0]     result,
    output logic [TAG_WIDTH-1:0]                done_tag
);

    import mult_pkg::*;

    localparam int EXT = 64 - data_width;

    logic [63:0] mcand;
    logic [63:0] mplier;

    // slice chain, entry i feeds slice i and entry i+1 is its output
    logic [63:0]          sum_chain    [STAGES:0];
    logic [63:0]          mplier_chain [STAGES:0];
    logic [63:0]          mcand_chain  [STAGES:0];
    mult_func_e           func_chain   [STAGES:0];
    logic [TAG_WIDTH-1:0] tag_chain    [STAGES:0];
    logic                 valid_chain  [STAGES:0];

    logic [data_width-1:0] product_half;

    // rs1 is the multiplicand, rs2 the multiplier
    always_comb begin
        case (op_func)
            MUL, MULH, MULHSU: mcand = {{EXT{op_rs1[data_width-1]}}, op_rs1};
            default:           mcand = {{EXT{1'b0}}, op_rs1};
        endcase
        case (op_func)
            MUL, MULH: mplier = {{EXT{op_rs2[data_width-1]}}, op_rs2};
            default:   mplier = {{EXT{1'b0}}, op_rs2};
        endcase
    end

    assign sum_chain[0]    = '0; // running sum starts at zero
    assign mplier_chain[0] = mplier;
    assign mcand_chain[0]  = mcand;
    assign func_chain[0]   = op_func;
    assign tag_chain[0]    = op_tag;
    assign valid_chain[0]  = op_valid;

    for (genvar i = 0; i < STAGES; i++) begin : g_stage
        mult_stage #(
            .STAGES    (STAGES),
            .TAG_WIDTH (TAG_WIDTH)
        ) u_stage (
            .clock       (clock),
            .reset       (reset),
            .stall       (stall),
            .start       (valid_chain[i]),   // previous done starts this slice
            .prev_sum    (sum_chain[i]),
            .mplier      (mplier_chain[i]),
            .mcand       (mcand_chain[i]),
            .func        (func_chain[i]),
            .tag_in      (tag_chain[i]),
            .product_sum (sum_chain[i+1]),
            .next_mplier (mplier_chain[i+1]),
            .next_mcand  (mcand_chain[i+1]),
            .next_func   (func_chain[i+1]),
            .tag_out     (tag_chain[i+1]),
            .done        (valid_chain[i+1])
        );
    end

    // MUL keeps the low word, the others the high word
    assign product_half = (func_chain[STAGES] == MUL) ?
                          sum_chain[STAGES][data_width-1:0] :
                          sum_chain[STAGES][2*data_width-1:data_width];

    // output register, frozen with the slices
    always_ff @(posedge clock) begin
        if (!stall) begin
            result   <= product_half;
            done_tag <= tag_chain[STAGES];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            done <= 1'b0;
        end else if (!stall) begin
            done <= valid_chain[STAGES];
        end
    end

    // back-pressure from the completion buffer must freeze the finished result
    a_done_held: assert property (
        @(posedge clock) disable iff (reset)
        stall |=> $stable(done)
    ) else $error("mult_pipe: done changed while stalled");

endmodule

`default_nettype wire

// ==== source/mult_pkg.sv ====
`default_nettype none

package mult_pkg;

    // architectural register width of the RV32 core
    parameter int unsigned data_width = 32;

    // multiply functions, encoded as the funct3 field of the RV32M instruction
    typedef enum logic [1:0] {
        MUL    = 2'd0, // low half, signed x signed
        MULH   = 2'd1, // high half, signed x signed
        MULHSU = 2'd2, // high half, signed rs1 x unsigned rs2
        MULHU  = 2'd3  // high half, unsigned x unsigned
    } mult_func_e;

endpackage

`default_nettype wire

// ==== source/mult_stage.sv ====
`default_nettype none

module mult_stage #(
    parameter int STAGES    = 4,
    parameter int TAG_WIDTH = 6
) (
    input  wire logic                   clock,
    input  wire logic                   reset,
    input  wire logic                   stall,
    input  wire logic                   start,
    input  wire logic [63:0]            prev_sum,
    input  wire logic [63:0]            mplier,
    input  wire logic [63:0]            mcand,
    input  wire mult_pkg::mult_func_e   func,
    input  wire logic [TAG_WIDTH-1:0]   tag_in,
    output logic [63:0]                 product_sum,
    output logic [63:0]                 next_mplier,
    output logic [63:0]                 next_mcand,
    output mult_pkg::mult_func_e        next_func,
    output logic [TAG_WIDTH-1:0]        tag_out,
    output logic                        done
);

    // multiplier bits consumed by each slice
    localparam int SHIFT = 64 / STAGES;

    logic [63:0] partial_product;
    logic [63:0] shifted_mplier;
    logic [63:0] shifted_mcand;

    assign partial_product = mplier[SHIFT-1:0] * mcand; // truncated to 64 bits

    // line up the operands for the next slice
    assign shifted_mplier = {{SHIFT{1'b0}}, mplier[63:SHIFT]};
    assign shifted_mcand  = {mcand[63-SHIFT:0], {SHIFT{1'b0}}};

    always_ff @(posedge clock) begin
        if (!stall) begin
            product_sum <= prev_sum + partial_product;
            next_mplier <= shifted_mplier;
            next_mcand  <= shifted_mcand;
            next_func   <= func;
            tag_out     <= tag_in; // tag rides along with its operands
        end
    end

    // valid flag of this slice
    always_ff @(posedge clock) begin
        if (reset) begin
            done <= 1'b0;
        end else if (!stall) begin
            done <= start;
        end
    end

endmodule

`default_nettype wire

// ==== source/mult_unit.sv ====
`default_nettype none

module mult_unit #(
    parameter int STAGES      = 4,  // 2, 4 or 8
    parameter int TAG_WIDTH   = 6,
    parameter int QUEUE_DEPTH = 4   // power of two
) (
    input  wire logic                           clock,
    input  wire logic                           reset,
    input  wire logic                           issue_valid,
    input  wire mult_pkg::mult_func_e           issue_func,
    input  wire logic [mult_pkg::data_width-1:0] issue_rs1,
    input  wire logic [mult_pkg::data_width-1:0] issue_rs2,
    input  wire logic [TAG_WIDTH-1:0]           issue_tag,
    input  wire logic                           complete_ready,
    output logic                                issue_ready,
    output logic                                complete_valid,
    output logic [mult_pkg::data_width-1:0]     complete_result,
    output logic [TAG_WIDTH-1:0]                complete_tag
);

    import mult_pkg::*;

    logic                  op_valid;
    mult_func_e            op_func;
    logic [data_width-1:0] op_rs1;
    logic [data_width-1:0] op_rs2;
    logic [TAG_WIDTH-1:0]  op_tag;
    logic                  done;
    logic [data_width-1:0] result;
    logic [TAG_WIDTH-1:0]  done_tag;
    logic                  stall; // from the completion buffer to queue and pipe

    mult_issue_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .TAG_WIDTH   (TAG_WIDTH)
    ) u_queue (
        .clock       (clock),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_func  (issue_func),
        .issue_rs1   (issue_rs1),
        .issue_rs2   (issue_rs2),
        .issue_tag   (issue_tag),
        .stall       (stall),
        .issue_ready (issue_ready),
        .op_valid    (op_valid),
        .op_func     (op_func),
        .op_rs1      (op_rs1),
        .op_rs2      (op_rs2),
        .op_tag      (op_tag)
    );

    mult_pipe #(
        .STAGES    (STAGES),
        .TAG_WIDTH (TAG_WIDTH)
    ) u_pipe (
        .clock    (clock),
        .reset    (reset),
        .stall    (stall),
        .op_valid (op_valid),
        .op_func  (op_func),
        .op_rs1   (op_rs1),
        .op_rs2   (op_rs2),
        .op_tag   (op_tag),
        .done     (done),
        .result   (result),
        .done_tag (done_tag)
    );

    mult_complete_buffer #(
        .TAG_WIDTH (TAG_WIDTH)
    ) u_complete (
        .clock           (clock),
        .reset           (reset),
        .done            (done),
        .result          (result),
        .done_tag        (done_tag),
        .complete_ready  (complete_ready),
        .stall           (stall),
        .complete_valid  (complete_valid),
        .complete_result (complete_result),
        .complete_tag    (complete_tag)
    );

endmodule

`default_nettype wire
